//--- cinird_asserts.sv
`timescale 1ns/1ps

module cinird_asserts import cinird_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input hist_state_e state_i,
  input logic        feat_valid_i,
  input logic        o_valid_i,
  input logic        read_finish_i,
  input logic        finish_i
);

  int unsigned fail_cnt = 0;

  // the source waits until the clear walk is over
  a_no_feature_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
    !(feat_valid_i && (state_i == HS_CLEAR)))
    else begin
      fail_cnt++;
      $error("feature strobe arrived while bins were being cleared");
    end

  a_valid_not_with_finish: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_valid_i && read_finish_i))
    else begin
      fail_cnt++;
      $error("o_valid and read_finish high in the same cycle");
    end

  a_finish_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    finish_i |=> !finish_i)
    else begin
      fail_cnt++;
      $error("finish stayed high for more than one cycle");
    end

  // data only leaves while the read sequencer runs
  a_valid_only_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid_i |-> (state_i == HS_READ))
    else begin
      fail_cnt++;
      $error("o_valid high outside HS_READ");
    end

endmodule

bind joint_histogram cinird_asserts i_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_i       (state_q),
  .feat_valid_i  (feat.valid),
  .o_valid_i     (o_valid_o),
  .read_finish_i (read_finish_o),
  .finish_i      (finish_o)
);

//--- cinird_datapath.sv
`timescale 1ns/1ps

module cinird_datapath import cinird_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  grayscale_i,
  input  logic        i_valid,
  input  logic        read_en,
  input  logic        start_i,
  output logic [31:0] histogram_o,
  output logic        o_valid,
  output logic        read_finish,
  output logic        finish,
  output logic        start_en
);

  logic    start_q;
  window_t win;
  logic    win_valid;
  logic    win_last;

  feature_if feat_if ();

  // falling edge of start_i, registered as a one-cycle clear
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q  <= 1'b0;
      start_en <= 1'b0;
    end else begin
      start_q  <= start_i;
      start_en <= start_q && !start_i;
    end
  end

  window_3x3 u_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (start_en),
    .pix_i       (grayscale_i),
    .pix_valid_i (i_valid),
    .win_o       (win),
    .win_valid_o (win_valid),
    .win_last_o  (win_last)
  );

  cinird_encoder u_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_i       (win),
    .win_valid_i (win_valid),
    .win_last_i  (win_last),
    .feat        (feat_if.enc)
  );

  joint_histogram u_hist (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_i       (start_en),
    .feat          (feat_if.hist),
    .read_en_i     (read_en),
    .count_o       (histogram_o),
    .o_valid_o     (o_valid),
    .read_finish_o (read_finish),
    .finish_o      (finish)
  );

endmodule

//--- cinird_defs.svh
`ifndef CINIRD_DEFS_SVH
`define CINIRD_DEFS_SVH

// frame geometry in pixels
`define COLS 16
`define ROWS 16

// minimum absolute neighbour difference counted by rd
`define RD_THRESH 16

// 2 ci values x 9 ni values x 9 rd values
`define HIST_BINS 162

// width of one histogram bin count
`define CNT_W 16

// window in to feature out, in cycles
`define ENC_LAT 4

`endif

//--- cinird_encoder.sv
`timescale 1ns/1ps
`include "cinird_defs.svh"

module cinird_encoder import cinird_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  window_t win_i,
  input  logic    win_valid_i,
  input  logic    win_last_i,
  feature_if.enc  feat
);

  localparam pixel_t RD_T = pixel_t'(`RD_THRESH);

  function automatic pixel_t min3(pixel_t a, pixel_t b, pixel_t c);
    pixel_t m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  function automatic pixel_t max3(pixel_t a, pixel_t b, pixel_t c);
    pixel_t m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  // max(min(a,b), min(max(a,b),c))
  function automatic pixel_t med3(pixel_t a, pixel_t b, pixel_t c);
    pixel_t lo;
    pixel_t hi;
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    hi = (hi < c) ? hi : c;
    return (lo > hi) ? lo : hi;
  endfunction

  pixel_t [2:0]        s1_lo;
  pixel_t [2:0]        s1_mi;
  pixel_t [2:0]        s1_hi;
  window_t             s1_win;
  pixel_t              s2_max_lo;
  pixel_t              s2_med_mi;
  pixel_t              s2_min_hi;
  window_t             s2_win;
  pixel_t              s3_med;
  window_t             s3_win;
  count9_t             ni_d;
  count9_t             rd_d;
  logic [`ENC_LAT-1:0] vld_sr;
  logic [`ENC_LAT-1:0] last_sr;

  // stage 1: sort each row of three
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      s1_lo[r] <= min3(win_i[3*r], win_i[3*r+1], win_i[3*r+2]);
      s1_mi[r] <= med3(win_i[3*r], win_i[3*r+1], win_i[3*r+2]);
      s1_hi[r] <= max3(win_i[3*r], win_i[3*r+1], win_i[3*r+2]);
    end
    s1_win <= win_i;
  end

  // stage 2: column extremes of the sorted rows
  always_ff @(posedge clk) begin
    s2_max_lo <= max3(s1_lo[0], s1_lo[1], s1_lo[2]);
    s2_med_mi <= med3(s1_mi[0], s1_mi[1], s1_mi[2]);
    s2_min_hi <= min3(s1_hi[0], s1_hi[1], s1_hi[2]);
    s2_win    <= s1_win;
  end

  // stage 3: median of nine
  always_ff @(posedge clk) begin
    s3_med <= med3(s2_max_lo, s2_med_mi, s2_min_hi);
    s3_win <= s2_win;
  end

  // stage 4 compares, centre excluded from both counts
  always_comb begin
    pixel_t diff;
    diff = '0;
    ni_d = '0;
    rd_d = '0;
    for (int i = 0; i < 9; i++) begin
      if (i != 4) begin
        diff = (s3_win[i] > s3_win[4]) ? s3_win[i] - s3_win[4] : s3_win[4] - s3_win[i];
        if (s3_win[i] >= s3_med) begin
          ni_d = ni_d + count9_t'(1);
        end
        if (diff >= RD_T) begin
          rd_d = rd_d + count9_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    feat.ci <= (s3_win[4] >= s3_med);
    feat.ni <= ni_d;
    feat.rd <= rd_d;
  end

  // strobes travel alongside the data stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr  <= '0;
      last_sr <= '0;
    end else begin
      vld_sr  <= {vld_sr[`ENC_LAT-2:0], win_valid_i};
      last_sr <= {last_sr[`ENC_LAT-2:0], win_valid_i && win_last_i};
    end
  end

  assign feat.valid = vld_sr[`ENC_LAT-1];
  assign feat.last  = last_sr[`ENC_LAT-1];

endmodule

//--- cinird_pkg.sv
package cinird_pkg;

  // one grayscale sample
  typedef logic [7:0] pixel_t;

  // 3x3 neighbourhood in raster order, centre at index 4
  typedef pixel_t [8:0] window_t;

  // neighbour count, 0 to 8
  typedef logic [3:0] count9_t;

  // ci*81 + ni*9 + rd
  typedef logic [7:0] bin_t;

  typedef enum logic [2:0] {
    HS_CLEAR,
    HS_COLLECT,
    HS_DRAIN,
    HS_READY,
    HS_READ,
    HS_FINISH
  } hist_state_e;

endpackage

//--- cinird_tb.sv
`timescale 1ns/1ps
`include "cinird_defs.svh"

module cinird_tb;

  localparam int N_FRAMES = 3;
  localparam int MARGIN   = 1000;
  localparam int TIMEOUT_CYCLES =
    N_FRAMES * (`HIST_BINS + `COLS * `ROWS + 2 * `HIST_BINS + 50) + MARGIN;
  localparam int WINDOWS = (`COLS - 2) * (`ROWS - 2);

  logic        clk;
  logic        rst_n;
  logic [7:0]  grayscale_i;
  logic        i_valid;
  logic        read_en;
  logic        start_i;
  logic [31:0] histogram_o;
  logic        o_valid;
  logic        read_finish;
  logic        finish;
  logic        start_en;

  integer      seed;
  int          errors;
  int          cycles;
  int          frame [`ROWS][`COLS];
  int unsigned expected_cnt [`HIST_BINS];
  int unsigned read_cnt [`HIST_BINS];
  int unsigned saved_cnt [`HIST_BINS];

  cinird_datapath i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .grayscale_i (grayscale_i),
    .i_valid     (i_valid),
    .read_en     (read_en),
    .start_i     (start_i),
    .histogram_o (histogram_o),
    .o_valid     (o_valid),
    .read_finish (read_finish),
    .finish      (finish),
    .start_en    (start_en)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("%0d errors", errors + 1 + i_dut.u_hist.i_asserts.fail_cnt);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  // reference model of the per-window codes and bin counts
  task automatic compute_expected();
    int win [9];
    int s [9];
    int tmp;
    int med;
    int ci;
    int ni;
    int rd;
    int d;
    foreach (expected_cnt[k]) expected_cnt[k] = 0;
    for (int r = 1; r < `ROWS - 1; r++) begin
      for (int c = 1; c < `COLS - 1; c++) begin
        for (int k = 0; k < 9; k++) begin
          win[k] = frame[r - 1 + k / 3][c - 1 + k % 3];
          s[k] = win[k];
        end
        for (int i = 0; i < 8; i++) begin
          for (int j = 0; j < 8 - i; j++) begin
            if (s[j] > s[j + 1]) begin
              tmp = s[j];
              s[j] = s[j + 1];
              s[j + 1] = tmp;
            end
          end
        end
        med = s[4];
        ci = (win[4] >= med) ? 1 : 0;
        ni = 0;
        rd = 0;
        for (int k = 0; k < 9; k++) begin
          if (k != 4) begin
            d = win[k] - win[4];
            if (d < 0) d = -d;
            if (win[k] >= med) ni++;
            if (d >= `RD_THRESH) rd++;
          end
        end
        expected_cnt[ci * 81 + ni * 9 + rd]++;
      end
    end
  endtask

  task automatic compare_histogram();
    for (int k = 0; k < `HIST_BINS; k++) begin
      check_value($sformatf("histogram_o bin %0d", k), expected_cnt[k], read_cnt[k]);
    end
  endtask

  // falling edge of start_i then wait out the clear walk
  task automatic start_frame();
    start_i = 1'b1;
    @(posedge clk);
    #2;
    start_i = 1'b0;
    @(posedge clk);
    #2;
    check_value("start_en", 1, start_en);
    @(posedge clk);
    #2;
    check_value("start_en", 0, start_en);
    repeat (`HIST_BINS + 1) @(posedge clk);
    #2;
  endtask

  task automatic send_frame();
    int waited;
    int pulses;
    for (int r = 0; r < `ROWS; r++) begin
      for (int c = 0; c < `COLS; c++) begin
        grayscale_i = frame[r][c][7:0];
        i_valid = 1'b1;
        @(posedge clk);
        #2;
      end
    end
    i_valid = 1'b0;
    grayscale_i = '0;
    waited = 0;
    pulses = 0;
    while (pulses == 0 && waited < 50) begin
      @(posedge clk);
      #2;
      waited++;
      if (finish) pulses++;
    end
    if (pulses == 0) begin
      errors++;
      $display("finish did not pulse after the last pixel of the frame");
    end else begin
      repeat (4) begin
        @(posedge clk);
        #2;
        if (finish) pulses++;
      end
      check_value("finish pulse count", 1, pulses);
    end
  endtask

  // throttle drops read_en at random to exercise back-pressure
  task automatic read_histogram(input bit throttle);
    int  idx;
    int  waited;
    int  finishes;
    bit  prev_en;
    bit  done;
    idx = 0;
    waited = 0;
    finishes = 0;
    done = 1'b0;
    while (!done && waited < 8 * `HIST_BINS) begin
      if (throttle) prev_en = ($random(seed) & 1) != 0;
      else prev_en = 1'b1;
      read_en = prev_en;
      @(posedge clk);
      #2;
      waited++;
      if (read_finish) begin
        finishes++;
        done = 1'b1;
        check_value("o_valid", 0, o_valid);
        check_value("bins read", `HIST_BINS, idx);
      end else if (o_valid) begin
        if (idx < `HIST_BINS) begin
          read_cnt[idx] = histogram_o;
        end else begin
          errors++;
          $display("more bins arrived than the histogram holds");
        end
        idx++;
      end
      if (!prev_en) check_value("o_valid", 0, o_valid);
    end
    read_en = 1'b0;
    if (!done) begin
      errors++;
      $display("read_finish did not pulse after the last bin");
    end else begin
      repeat (3) begin
        @(posedge clk);
        #2;
        if (read_finish) finishes++;
      end
      check_value("read_finish pulse count", 1, finishes);
    end
  endtask

  task automatic flat_frame_single_bin();
    foreach (frame[r, c]) frame[r][c] = 100;
    start_frame();
    send_frame();
    read_histogram(1'b0);
    // every flat window lands in bin 153 (ci 1 ni 8 rd 0)
    for (int k = 0; k < `HIST_BINS; k++) begin
      check_value($sformatf("histogram_o bin %0d", k), (k == 153) ? WINDOWS : 0, read_cnt[k]);
    end
  endtask

  task automatic random_frame_with_throttle();
    int unsigned sum;
    foreach (frame[r, c]) frame[r][c] = $random(seed) & 8'hff;
    compute_expected();
    start_frame();
    send_frame();
    read_histogram(1'b0);
    compare_histogram();
    sum = 0;
    foreach (read_cnt[k]) sum += read_cnt[k];
    check_value("histogram sum", WINDOWS, sum);
    read_histogram(1'b1);
    compare_histogram();
  endtask

  task automatic checkerboard_after_clear();
    foreach (frame[r, c]) frame[r][c] = ((r + c) % 2 != 0) ? 200 : 40;
    compute_expected();
    start_frame();
    send_frame();
    read_histogram(1'b0);
    compare_histogram();
    saved_cnt = read_cnt;
    read_histogram(1'b0);
    for (int k = 0; k < `HIST_BINS; k++) begin
      check_value($sformatf("re-read bin %0d", k), saved_cnt[k], read_cnt[k]);
    end
  endtask

  initial begin
    seed = 32'hc498;
    errors = 0;
    cycles = 0;
    rst_n = 1'b0;
    grayscale_i = '0;
    i_valid = 1'b0;
    read_en = 1'b0;
    start_i = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    flat_frame_single_bin();
    random_frame_with_throttle();
    checkerboard_after_clear();
    errors += i_dut.u_hist.i_asserts.fail_cnt;
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- feature_if.sv
`timescale 1ns/1ps

// codes of one 3x3 window, one strobe per window
interface feature_if import cinird_pkg::*; ();

  logic    valid;
  logic    last;
  logic    ci;
  count9_t ni;
  count9_t rd;

  modport enc (
    output valid, last, ci, ni, rd
  );

  modport hist (
    input valid, last, ci, ni, rd
  );

endinterface

//--- joint_histogram.sv
`timescale 1ns/1ps
`include "cinird_defs.svh"

module joint_histogram import cinird_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clear_i,
  feature_if.hist     feat,
  input  logic        read_en_i,
  output logic [31:0] count_o,
  output logic        o_valid_o,
  output logic        read_finish_o,
  output logic        finish_o
);

  localparam bin_t LAST_BIN = bin_t'(`HIST_BINS - 1);
  localparam bin_t END_BIN  = bin_t'(`HIST_BINS);

  logic [`CNT_W-1:0] cnt_mem [`HIST_BINS];
  hist_state_e       state_q;
  bin_t              addr_q;
  bin_t              bin_d;
  logic              rd_fire;

  // increment pipeline
  logic              s1_valid;
  logic              s1_last;
  bin_t              s1_bin;
  logic              s2_valid;
  logic              s2_last;
  bin_t              s2_bin;
  logic [`CNT_W-1:0] s2_cnt;
  logic [`CNT_W-1:0] s2_next;
  logic [`CNT_W-1:0] count_q;

  assign bin_d = (feat.ci ? bin_t'(81) : bin_t'(0))
               + bin_t'(feat.ni) * bin_t'(9)
               + bin_t'(feat.rd);

  assign s2_next = s2_cnt + `CNT_W'(1);

  // a bin is read out in READY or while READ has bins left
  assign rd_fire = read_en_i &&
                   ((state_q == HS_READY) || ((state_q == HS_READ) && (addr_q != END_BIN)));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else if (clear_i) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else begin
      s1_valid <= feat.valid && (state_q == HS_COLLECT);
      s1_last  <= feat.valid && feat.last;
      s2_valid <= s1_valid;
      s2_last  <= s1_valid && s1_last;
    end
  end

  always_ff @(posedge clk) begin
    s1_bin <= bin_d;
    s2_bin <= s1_bin;
    // bin ahead is still in flight, take its new value
    if (s2_valid && (s2_bin == s1_bin)) begin
      s2_cnt <= s2_next;
    end else begin
      s2_cnt <= cnt_mem[s1_bin];
    end
  end

  // single write port, shared by clear and count
  always_ff @(posedge clk) begin
    if (state_q == HS_CLEAR) begin
      cnt_mem[addr_q] <= '0;
    end else if (s2_valid) begin
      cnt_mem[s2_bin] <= s2_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      count_q <= cnt_mem[addr_q];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q       <= HS_READY;
      addr_q        <= '0;
      o_valid_o     <= 1'b0;
      read_finish_o <= 1'b0;
      finish_o      <= 1'b0;
    end else if (clear_i) begin
      state_q       <= HS_CLEAR;
      addr_q        <= '0;
      o_valid_o     <= 1'b0;
      read_finish_o <= 1'b0;
      finish_o      <= 1'b0;
    end else begin
      o_valid_o     <= rd_fire;
      read_finish_o <= 1'b0;
      finish_o      <= 1'b0;
      unique case (state_q)
        HS_CLEAR: begin
          if (addr_q == LAST_BIN) begin
            state_q <= HS_COLLECT;
            addr_q  <= '0;
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        HS_COLLECT: begin
          if (feat.valid && feat.last) begin
            state_q <= HS_DRAIN;
          end
        end
        // wait for the last increment to land
        HS_DRAIN: begin
          if (s2_valid && s2_last) begin
            state_q  <= HS_READY;
            finish_o <= 1'b1;
          end
        end
        HS_READY: begin
          if (read_en_i) begin
            state_q <= HS_READ;
            addr_q  <= addr_q + 1'b1;
          end
        end
        HS_READ: begin
          if (read_en_i) begin
            if (addr_q == END_BIN) begin
              state_q       <= HS_FINISH;
              addr_q        <= '0;
              read_finish_o <= 1'b1;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        HS_FINISH: state_q <= HS_READY;
        default:   state_q <= HS_READY;
      endcase
    end
  end

  assign count_o = {{(32 - `CNT_W){1'b0}}, count_q};

endmodule

//--- sources.f
+incdir+.
cinird_pkg.sv
feature_if.sv
window_3x3.sv
cinird_encoder.sv
joint_histogram.sv
cinird_datapath.sv
cinird_asserts.sv
cinird_tb.sv

//--- window_3x3.sv
`timescale 1ns/1ps
`include "cinird_defs.svh"

module window_3x3 import cinird_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    clear_i,
  input  pixel_t  pix_i,
  input  logic    pix_valid_i,
  output window_t win_o,
  output logic    win_valid_o,
  output logic    win_last_o
);

  localparam int COL_W = $clog2(`COLS);
  localparam int ROW_W = $clog2(`ROWS);

  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;
  logic             col_end;
  logic             row_end;
  logic             interior;

  // lb1 holds the previous row, lb2 the row before it
  pixel_t  lb1_mem [`COLS];
  pixel_t  lb2_mem [`COLS];
  pixel_t  above1;
  pixel_t  above2;
  window_t win_q;

  assign col_end  = (col_q == COL_W'(`COLS - 1));
  assign row_end  = (row_q == ROW_W'(`ROWS - 1));
  assign interior = (row_q >= ROW_W'(2)) && (col_q >= COL_W'(2));
  assign above1   = lb1_mem[col_q];
  assign above2   = lb2_mem[col_q];

  // raster position of the incoming pixel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (clear_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pix_valid_i) begin
      if (col_end) begin
        col_q <= '0;
        row_q <= row_end ? '0 : row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // line buffers and the sliding 3x3 window
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      lb1_mem[col_q] <= pix_i;
      lb2_mem[col_q] <= above1;
      // shift left, new column enters on the right
      win_q[0] <= win_q[1];
      win_q[1] <= win_q[2];
      win_q[2] <= above2;
      win_q[3] <= win_q[4];
      win_q[4] <= win_q[5];
      win_q[5] <= above1;
      win_q[6] <= win_q[7];
      win_q[7] <= win_q[8];
      win_q[8] <= pix_i;
    end
  end

  // window is complete one cycle after an interior pixel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= pix_valid_i && interior && !clear_i;
      win_last_o  <= pix_valid_i && interior && row_end && col_end && !clear_i;
    end
  end

  assign win_o = win_q;

endmodule
